// File: superres_top.f
logic/superres_pkg.sv
logic/neighborhood_capture.sv
logic/coef_store.sv
logic/conv_engine.sv
logic/pixel_writer.sv
logic/superres_top.sv
tests/superres_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module superres_tb \
    -f superres_top.f -o superres_sim \
    && ./obj_dir/superres_sim 2>&1 | tee sim.log
grep -qs "^Done: no errors$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// File: tests/superres_input.txt
# W addr data  writes one coefficient, both hex, data signed
# P name p0 .. p8 expected  window taps row*3+col and result, pixels hex BBGGRR
# F level  expected process_done after the pixel before it
W 04 01
W 1b 02
W 28 01
W 4c 02
W 50 ff
W 51 05
W 52 fe
W 53 0a
P zero_bias 000000 000000 000000 000000 000000 000000 000000 000000 000000 0a0005
P mid 000010 000000 000000 000000 203040 000000 000000 000000 080000 424e45
P sat 0000ff 000000 000000 000000 ffffff 000000 000000 000000 000000 ffffff
P neg 000000 000000 000000 000000 000000 000000 000000 000000 ff0000 000005
P mix 000007 ffffff 123456 abcdef 102030 010203 808080 7f7f7f 050000 252c35
F 0
P zero_end 000000 000000 000000 000000 000000 000000 000000 000000 000000 0a0005
F 1
# Red output only, new center weight, a green tap and a new bias
W 04 02
W 0b 03
W 51 f0
P rewrite_r 000010 000000 000400 000000 203040 000000 000000 000000 080000 424e7c
F 0
# Blue bias pushed negative
W 53 80
P rewrite_b 000010 000000 000000 000000 203040 000000 000000 000000 080000 004e70
F 0

// File: tests/superres_tb.sv
`timescale 1ns/1ps

module superres_tb import superres_pkg::*; ();

    localparam int FRAME_PIXELS = 6;
    localparam int PIXEL_TIMEOUT = 500;

    logic     clk;
    logic     rst_n;
    coef_wr_t coef_wr;
    logic     start_process;
    window_t  neighborhood;
    pixel_t   pixel_out;
    logic     pixel_done;
    logic     process_done;

    int pixel_checks;
    int frame_checks;

    superres_top #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) superres_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .coef_wr       (coef_wr),
        .start_process (start_process),
        .neighborhood  (neighborhood),
        .pixel_out     (pixel_out),
        .pixel_done    (pixel_done),
        .process_done  (process_done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH %s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("MISMATCH %s: expected %b, actual %b",
                                      name, expected, actual));
        end
    endtask

    task automatic write_coef(input coef_addr_t addr, input coef_t data);
        coef_wr.we   = 1'b1;
        coef_wr.addr = addr;
        coef_wr.data = data;
        @(negedge clk);
        coef_wr.we = 1'b0;
    endtask

    task automatic run_pixel(input string name, input window_t win, input pixel_t expected);
        int   cycles;
        logic closes_frame;

        // Last pixel of a frame raises process_done together with pixel_done
        closes_frame = ((pixel_checks + 1) % FRAME_PIXELS) == 0;
        neighborhood  = win;
        start_process = 1'b1;
        @(negedge clk);
        start_process = 1'b0;
        check_flag({name, " process_done after start"}, 1'b0, process_done);
        // Captured window must not follow the input any more
        neighborhood = ~win;
        cycles = 0;
        while (!pixel_done && cycles < PIXEL_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!pixel_done) begin
            stop_with_error($sformatf("%s: pixel_done never came within %0d cycles",
                                      name, PIXEL_TIMEOUT));
        end
        check_pixel(name, expected, pixel_out);
        check_flag({name, " process_done with pixel_done"}, closes_frame, process_done);
        @(negedge clk);
        check_flag({name, " pixel_done pulse"}, 1'b0, pixel_done);
        pixel_checks++;
    endtask

    initial begin
        int               fd;
        int               n;
        string            kind;
        string            name;
        logic [8*256-1:0] skip;
        coef_addr_t       addr;
        coef_t            data;
        pixel_t           px;
        pixel_t           expected;
        window_t          win;
        logic             flag;

        rst_n         = 1'b0;
        coef_wr       = '0;
        start_process = 1'b0;
        neighborhood  = '0;
        pixel_checks  = 0;
        frame_checks  = 0;

        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        check_pixel("reset pixel_out", '0, pixel_out);
        check_flag("reset pixel_done", 1'b0, pixel_done);
        check_flag("reset process_done", 1'b0, process_done);

        fd = $fopen("tests/superres_input.txt", "r");
        if (fd == 0) begin
            stop_with_error("Cannot open the input file tests/superres_input.txt");
        end

        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                n = $fgets(skip, fd);
            end else if (kind == "W") begin
                n = $fscanf(fd, "%h %h", addr, data);
                if (n != 2) begin
                    stop_with_error("A coefficient line in the input file is incomplete");
                end
                write_coef(addr, data);
            end else if (kind == "P") begin
                n = $fscanf(fd, "%s", name);
                // Tap k sits at pixel slot k of the window
                for (int k = 0; k < TAPS; k++) begin
                    n = $fscanf(fd, "%h", px);
                    win[k * $bits(pixel_t) +: $bits(pixel_t)] = px;
                end
                n = $fscanf(fd, "%h", expected);
                if (n != 1) begin
                    stop_with_error({"Pixel line ", name, " in the input file is incomplete"});
                end
                run_pixel(name, win, expected);
            end else if (kind == "F") begin
                n = $fscanf(fd, "%h", flag);
                if (n != 1) begin
                    stop_with_error("A frame line in the input file is incomplete");
                end
                frame_checks++;
                check_flag($sformatf("frame check %0d process_done", frame_checks),
                           flag, process_done);
            end else begin
                stop_with_error({"Unknown line kind ", kind, " in the input file"});
            end
        end
        $fclose(fd);

        if (pixel_checks > 0 && frame_checks > 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_with_error("The input file held no pixel or no frame checks");
        end
    end

endmodule

// File: logic/superres_top.sv
`timescale 1ns/1ps

module superres_top import superres_pkg::*; #(
    parameter int FRAME_PIXELS = 76800
) (
    input  logic     clk,
    input  logic     rst_n,
    input  coef_wr_t coef_wr,
    input  logic     start_process,
    input  window_t  neighborhood,
    output pixel_t   pixel_out,
    output logic     pixel_done,
    output logic     process_done
);

    window_t      window;
    logic         window_valid;
    logic         engine_idle;
    coef_addr_t   coef_rd_addr;
    coef_t        coef_rd_data;
    chan_result_t result;

    neighborhood_capture neighborhood_capture_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_process (start_process),
        .neighborhood  (neighborhood),
        .engine_idle   (engine_idle),
        .window        (window),
        .window_valid  (window_valid)
    );

    coef_store coef_store_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .coef_wr (coef_wr),
        .rd_addr (coef_rd_addr),
        .rd_data (coef_rd_data)
    );

    conv_engine conv_engine_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .window       (window),
        .window_valid (window_valid),
        .coef_rd_addr (coef_rd_addr),
        .coef_rd_data (coef_rd_data),
        .engine_idle  (engine_idle),
        .result       (result)
    );

    pixel_writer #(
        .FRAME_PIXELS (FRAME_PIXELS)
    ) pixel_writer_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .result        (result),
        .start_process (start_process),
        .pixel_out     (pixel_out),
        .pixel_done    (pixel_done),
        .process_done  (process_done)
    );

endmodule

// File: logic/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer import superres_pkg::*; #(
    parameter int FRAME_PIXELS = 76800
) (
    input  logic         clk,
    input  logic         rst_n,
    input  chan_result_t result,
    input  logic         start_process,
    output pixel_t       pixel_out,
    output logic         pixel_done,
    output logic         process_done
);

    localparam int CNT_W = $clog2(FRAME_PIXELS + 1);

    logic [CNT_W-1:0] pixel_cnt;
    channel_t         sat;
    pixel_t           stage;
    pixel_t           stage_next;
    logic             last_chan;
    logic             frame_end;

    // ReLU with clamp to 8 bits
    always_comb begin
        if (result.acc < 0) begin
            sat = '0;
        end else if (result.acc > 255) begin
            sat = 8'hff;
        end else begin
            sat = channel_t'(result.acc[7:0]);
        end
    end

    always_comb begin
        stage_next = stage;
        stage_next[result.chan * $bits(channel_t) +: $bits(channel_t)] = sat;
    end

    assign last_chan = result.valid && (result.chan == 2'(CHANNELS - 1));
    assign frame_end = last_chan && (pixel_cnt == CNT_W'(FRAME_PIXELS - 1));

    always_ff @(posedge clk) begin
        if (result.valid) begin
            stage <= stage_next;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pixel_out    <= '0;
            pixel_done   <= 1'b0;
            process_done <= 1'b0;
            pixel_cnt    <= '0;
        end else begin
            pixel_done <= last_chan;
            if (last_chan) begin
                pixel_out <= stage_next;
                pixel_cnt <= frame_end ? '0 : pixel_cnt + 1'b1;
            end
            // Frame end wins over a start in the same cycle
            if (frame_end) begin
                process_done <= 1'b1;
            end else if (start_process) begin
                process_done <= 1'b0;
            end
        end
    end

endmodule

// File: logic/conv_engine.sv
`timescale 1ns/1ps

module conv_engine import superres_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  window_t      window,
    input  logic         window_valid,
    output coef_addr_t   coef_rd_addr,
    input  coef_t        coef_rd_data,
    output logic         engine_idle,
    output chan_result_t result
);

    engine_state_t state;

    logic [1:0] out_ch;
    logic [1:0] in_ch;
    logic [3:0] tap;
    logic       last_tap;
    logic       last_out;

    channel_t           sample;
    logic signed [16:0] product;
    logic               prod_valid;
    acc_t               acc;

    // Not idle while a captured window waits to be picked up
    assign engine_idle = (state == IDLE) && !window_valid;

    assign last_tap = (in_ch == 2'(CHANNELS - 1)) && (tap == 4'(TAPS - 1));
    assign last_out = (out_ch == 2'(CHANNELS - 1));

    always_comb begin
        if (state == BIAS) begin
            coef_rd_addr = coef_addr_t'(COEF_WEIGHTS + out_ch);
        end else begin
            coef_rd_addr = coef_addr_t'((out_ch * CHANNELS + in_ch) * TAPS + tap);
        end
    end

    assign sample = window[tap * $bits(pixel_t) + in_ch * $bits(channel_t) +: $bits(channel_t)];

    // Multiplier stage, sample zero extended so only the weight carries a sign
    always_ff @(posedge clk) begin
        product <= $signed({1'b0, sample}) * coef_rd_data;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            out_ch     <= '0;
            in_ch      <= '0;
            tap        <= '0;
            prod_valid <= 1'b0;
            acc        <= '0;
            result     <= '0;
        end else begin
            result.valid <= 1'b0;
            case (state)
                IDLE: begin
                    if (window_valid) begin
                        state <= MAC;
                    end
                end
                MAC: begin
                    // Product of the previous tap lands here
                    prod_valid <= 1'b1;
                    if (prod_valid) begin
                        acc <= acc + acc_t'(product);
                    end
                    if (tap == 4'(TAPS - 1)) begin
                        tap   <= '0;
                        in_ch <= in_ch + 2'd1;
                    end else begin
                        tap <= tap + 4'd1;
                    end
                    if (last_tap) begin
                        in_ch <= '0;
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    prod_valid <= 1'b0;
                    acc        <= acc + acc_t'(product);
                    state      <= BIAS;
                end
                BIAS: begin
                    result.valid <= 1'b1;
                    result.chan  <= out_ch;
                    result.acc   <= acc + acc_t'(coef_rd_data);
                    acc          <= '0;
                    if (last_out) begin
                        out_ch <= '0;
                        state  <= IDLE;
                    end else begin
                        out_ch <= out_ch + 2'd1;
                        state  <= MAC;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Capture side must hold off while a pixel is in progress
    a_valid_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        window_valid |-> (state == IDLE)
    );

endmodule

// File: logic/coef_store.sv
`timescale 1ns/1ps

module coef_store import superres_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  coef_wr_t   coef_wr,
    input  coef_addr_t rd_addr,
    output coef_t      rd_data
);

    // Weights at 0..80, biases at 81..83
    coef_t mem [COEF_DEPTH];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < COEF_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (coef_wr.we) begin
            mem[coef_wr.addr] <= coef_wr.data;
        end
    end

    // Combinational read, engine registers the product
    assign rd_data = mem[rd_addr];

    // Loader must stay inside the weight and bias range
    a_wr_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        coef_wr.we |-> (coef_wr.addr < COEF_DEPTH)
    );

endmodule

// File: logic/neighborhood_capture.sv
`timescale 1ns/1ps

module neighborhood_capture import superres_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    start_process,
    input  window_t neighborhood,
    input  logic    engine_idle,
    output window_t window,
    output logic    window_valid
);

    logic accept;

    // Starts during a computation are dropped
    assign accept = start_process && engine_idle;

    // Window stays frozen until the next accepted start
    always_ff @(posedge clk) begin
        if (accept) begin
            window <= neighborhood;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            window_valid <= 1'b0;
        end else begin
            window_valid <= accept;
        end
    end

    // Engine must drop engine_idle as soon as it sees a window
    a_single_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        window_valid |=> !window_valid
    );

endmodule

// File: logic/superres_pkg.sv
package superres_pkg;

    // Kernel geometry
    localparam int TAPS = 9;
    localparam int CHANNELS = 3;

    // Weights first, then one bias per output channel
    localparam int COEF_WEIGHTS = 81;
    localparam int COEF_DEPTH = 84;

    typedef logic [7:0] channel_t;

    // Channel c at bits c*8 upward
    typedef logic [23:0] pixel_t;

    typedef logic signed [7:0] coef_t;
    typedef logic [6:0] coef_addr_t;

    // 27 products of 8x9 bits plus a bias
    typedef logic signed [21:0] acc_t;

    // Tap k = row*3 + col, one RGB pixel per tap
    typedef logic [215:0] window_t;

    typedef struct packed {
        logic       we;
        coef_addr_t addr;
        coef_t      data;
    } coef_wr_t;

    typedef struct packed {
        logic       valid;
        logic [1:0] chan;
        acc_t       acc;
    } chan_result_t;

    typedef enum logic [1:0] {
        IDLE,
        MAC,
        DRAIN,
        BIAS
    } engine_state_t;

endpackage
